//--- verilog/rv_core_pkg.sv
// Shared widths, opcodes, ALU operations and pipe structs, compiled ahead of every RTL module
package rv_core_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////////////////////////

  // Data path width
  localparam int unsigned XLEN       = 32;
  // Register index width, x0 to x31
  localparam int unsigned REG_ADDR_W = 5;
  // Architectural register count
  localparam int unsigned NUM_REGS   = 32;

  //////////////////////////////////////////////////////////////////////
  // Accepted major opcodes
  //////////////////////////////////////////////////////////////////////

  // Register-register ALU group
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  // Register-immediate ALU group
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  // ALU operations carried from decode to execute
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////////////////////////

  // R-type layout, funct7 and rs2 in the upper bits
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_r_t;

  // I-type layout, 12-bit immediate in the upper bits
  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_i_t;

  // Same 32-bit word, read as either layout
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // Decoded item between ID and EX
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] rd;
  } id_ex_pipe_t;

  // Retiring item between EX and WB
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       result;
  } ex_wb_pipe_t;

endpackage

//--- verilog/rv_register_file.sv
// Register file with two combinational read ports and one write port fed by the EX/WB pipe
`timescale 1ns/1ps

module rv_register_file (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_b_o,
  input  rv_core_pkg::ex_wb_pipe_t           ex_wb_pipe_i
);

  // x1 to x31, x0 has no storage
  logic [rv_core_pkg::NUM_REGS-1:1][rv_core_pkg::XLEN-1:0] regs;
  logic                                                    we;

  // Legal retirements only, and never x0
  assign we = ex_wb_pipe_i.valid && !ex_wb_pipe_i.illegal && (ex_wb_pipe_i.rd != '0);

  // Write at the edge closing the WB cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < rv_core_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[ex_wb_pipe_i.rd] <= ex_wb_pipe_i.result;
    end
  end

  // No write bypass here, ID forwards from WB instead
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

  // Retiring into x0 leaves every register untouched
  a_no_write_to_x0 : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (ex_wb_pipe_i.valid && (ex_wb_pipe_i.rd == '0)) |=> (regs == $past(regs))
  );

endmodule

//--- verilog/rv_id_stage.sv
// Decode stage that turns strobed instruction words into forwarded ALU items for the EX stage
`timescale 1ns/1ps

module rv_id_stage (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               instr_valid_i,
  input  rv_core_pkg::instr_u                instr_i,
  // EX forwarding source
  input  logic                               ex_fwd_valid_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] ex_fwd_rd_i,
  input  logic [rv_core_pkg::XLEN-1:0]       ex_fwd_data_i,
  // WB forwarding source
  input  rv_core_pkg::ex_wb_pipe_t           ex_wb_pipe_i,
  // Register file reads
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [rv_core_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [rv_core_pkg::XLEN-1:0]       rf_rdata_b_i,
  output rv_core_pkg::id_ex_pipe_t           id_ex_pipe_o
);

  // Decoder outputs
  rv_core_pkg::alu_op_e         alu_op;
  logic                         use_imm;
  logic                         dec_illegal;
  logic [rv_core_pkg::XLEN-1:0] imm_ext;

  // Resolved operands and next pipe item
  logic                         wb_fwd_valid;
  logic [rv_core_pkg::XLEN-1:0] operand_a;
  logic [rv_core_pkg::XLEN-1:0] rs2_value;
  rv_core_pkg::id_ex_pipe_t     id_ex_next;

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op      = rv_core_pkg::ALU_ADD;
    use_imm     = 1'b0;
    dec_illegal = 1'b0;
    // Sign-extended I immediate by default
    imm_ext     = {{(rv_core_pkg::XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
    case (instr_i.r.opcode)
      rv_core_pkg::OPCODE_OP: begin
        // funct7 and funct3 together pick the operation
        case ({instr_i.r.funct7, instr_i.r.funct3})
          {7'b0000000, 3'b000}: alu_op = rv_core_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = rv_core_pkg::ALU_SUB;
          {7'b0000000, 3'b001}: alu_op = rv_core_pkg::ALU_SLL;
          {7'b0000000, 3'b010}: alu_op = rv_core_pkg::ALU_SLT;
          {7'b0000000, 3'b011}: alu_op = rv_core_pkg::ALU_SLTU;
          {7'b0000000, 3'b100}: alu_op = rv_core_pkg::ALU_XOR;
          {7'b0000000, 3'b101}: alu_op = rv_core_pkg::ALU_SRL;
          {7'b0100000, 3'b101}: alu_op = rv_core_pkg::ALU_SRA;
          {7'b0000000, 3'b110}: alu_op = rv_core_pkg::ALU_OR;
          {7'b0000000, 3'b111}: alu_op = rv_core_pkg::ALU_AND;
          default:              dec_illegal = 1'b1;
        endcase
      end
      rv_core_pkg::OPCODE_OP_IMM: begin
        use_imm = 1'b1;
        case (instr_i.i.funct3)
          3'b000: alu_op = rv_core_pkg::ALU_ADD;
          3'b010: alu_op = rv_core_pkg::ALU_SLT;
          3'b011: alu_op = rv_core_pkg::ALU_SLTU;
          3'b100: alu_op = rv_core_pkg::ALU_XOR;
          3'b110: alu_op = rv_core_pkg::ALU_OR;
          3'b111: alu_op = rv_core_pkg::ALU_AND;
          3'b001: begin
            // SLLI needs a zero upper immediate
            alu_op  = rv_core_pkg::ALU_SLL;
            imm_ext = {{(rv_core_pkg::XLEN-5){1'b0}}, instr_i.i.imm12[4:0]};
            if (instr_i.i.imm12[11:5] != 7'b0000000) begin
              dec_illegal = 1'b1;
            end
          end
          default: begin
            // funct3 101, upper immediate tells SRLI from SRAI
            imm_ext = {{(rv_core_pkg::XLEN-5){1'b0}}, instr_i.i.imm12[4:0]};
            if (instr_i.i.imm12[11:5] == 7'b0000000) begin
              alu_op = rv_core_pkg::ALU_SRL;
            end else if (instr_i.i.imm12[11:5] == 7'b0100000) begin
              alu_op = rv_core_pkg::ALU_SRA;
            end else begin
              dec_illegal = 1'b1;
            end
          end
        endcase
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Operand forwarding
  //////////////////////////////////////////////////////////////////////

  // Illegal items never forward
  assign wb_fwd_valid = ex_wb_pipe_i.valid && !ex_wb_pipe_i.illegal;

  // x0, then EX, then WB, then the register file
  function automatic logic [rv_core_pkg::XLEN-1:0] resolve_operand(
    input logic [rv_core_pkg::REG_ADDR_W-1:0] raddr,
    input logic [rv_core_pkg::XLEN-1:0]       rf_rdata
  );
    logic [rv_core_pkg::XLEN-1:0] value;
    if (raddr == '0) begin
      value = '0;
    end else if (ex_fwd_valid_i && (ex_fwd_rd_i == raddr)) begin
      value = ex_fwd_data_i;
    end else if (wb_fwd_valid && (ex_wb_pipe_i.rd == raddr)) begin
      value = ex_wb_pipe_i.result;
    end else begin
      value = rf_rdata;
    end
    return value;
  endfunction

  // rs2 field read even for I-type, the immediate overrides it
  assign rf_raddr_a_o = instr_i.r.rs1;
  assign rf_raddr_b_o = instr_i.r.rs2;

  always_comb begin
    operand_a = resolve_operand(rf_raddr_a_o, rf_rdata_a_i);
    rs2_value = resolve_operand(rf_raddr_b_o, rf_rdata_b_i);
  end

  // Next ID/EX item
  always_comb begin
    id_ex_next.valid     = instr_valid_i;
    id_ex_next.illegal   = instr_valid_i && dec_illegal;
    id_ex_next.alu_op    = alu_op;
    id_ex_next.operand_a = operand_a;
    id_ex_next.operand_b = use_imm ? imm_ext : rs2_value;
    id_ex_next.rd        = instr_i.r.rd;
  end

  // ID/EX register, one cycle, never stalls
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_ex_pipe_o.valid   <= 1'b0;
      id_ex_pipe_o.illegal <= 1'b0;
    end else begin
      id_ex_pipe_o <= id_ex_next;
    end
  end

  // Pipe comes out of reset empty
  a_id_ex_empty_after_reset : assert property (
    @(posedge clk_i) reset_i |=> !id_ex_pipe_o.valid
  );

endmodule

//--- verilog/rv_ex_stage.sv
// Execute stage with the ALU, feeding forwarding back to ID and the EX/WB pipe to write back
`timescale 1ns/1ps

module rv_ex_stage (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  rv_core_pkg::id_ex_pipe_t           id_ex_pipe_i,
  // Combinational result for the ID stage
  output logic                               ex_fwd_valid_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] ex_fwd_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]       ex_fwd_data_o,
  output rv_core_pkg::ex_wb_pipe_t           ex_wb_pipe_o
);

  // ALU internals
  logic [4:0]                   shamt;
  logic                         lt_signed;
  logic                         lt_unsigned;
  logic [rv_core_pkg::XLEN-1:0] alu_result;

  // Low five bits of b for every shift
  assign shamt = id_ex_pipe_i.operand_b[4:0];

  // Both compares, SLT and SLTU pick one
  assign lt_signed   = $signed(id_ex_pipe_i.operand_a) < $signed(id_ex_pipe_i.operand_b);
  assign lt_unsigned = id_ex_pipe_i.operand_a < id_ex_pipe_i.operand_b;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_pipe_i.alu_op)
      rv_core_pkg::ALU_ADD:  alu_result = id_ex_pipe_i.operand_a + id_ex_pipe_i.operand_b;
      rv_core_pkg::ALU_SUB:  alu_result = id_ex_pipe_i.operand_a - id_ex_pipe_i.operand_b;
      rv_core_pkg::ALU_SLL:  alu_result = id_ex_pipe_i.operand_a << shamt;
      rv_core_pkg::ALU_SLT:  alu_result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_signed};
      rv_core_pkg::ALU_SLTU: alu_result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_unsigned};
      rv_core_pkg::ALU_XOR:  alu_result = id_ex_pipe_i.operand_a ^ id_ex_pipe_i.operand_b;
      rv_core_pkg::ALU_SRL:  alu_result = id_ex_pipe_i.operand_a >> shamt;
      // Sign bit fills from the left
      rv_core_pkg::ALU_SRA:  alu_result = $signed(id_ex_pipe_i.operand_a) >>> shamt;
      rv_core_pkg::ALU_OR:   alu_result = id_ex_pipe_i.operand_a | id_ex_pipe_i.operand_b;
      rv_core_pkg::ALU_AND:  alu_result = id_ex_pipe_i.operand_a & id_ex_pipe_i.operand_b;
      default:               alu_result = '0;
    endcase
  end

  // Forward only valid, legal items
  assign ex_fwd_valid_o = id_ex_pipe_i.valid && !id_ex_pipe_i.illegal;
  assign ex_fwd_rd_o    = id_ex_pipe_i.rd;
  assign ex_fwd_data_o  = alu_result;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_wb_pipe_o.valid   <= 1'b0;
      ex_wb_pipe_o.illegal <= 1'b0;
    end else begin
      ex_wb_pipe_o.valid   <= id_ex_pipe_i.valid;
      ex_wb_pipe_o.illegal <= id_ex_pipe_i.illegal;
      ex_wb_pipe_o.rd      <= id_ex_pipe_i.rd;
      // Rejected words retire with a zero result
      ex_wb_pipe_o.result  <= id_ex_pipe_i.illegal ? '0 : alu_result;
    end
  end

  // Illegal item decoded in ID reaches WB flagged and zeroed
  a_illegal_retires_zero : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (id_ex_pipe_i.valid && id_ex_pipe_i.illegal) |=>
      (ex_wb_pipe_o.valid && ex_wb_pipe_o.illegal && (ex_wb_pipe_o.result == '0))
  );

endmodule

//--- verilog/rv_core.sv
// Core top level that ties the ID stage, EX stage and register file into the ALU pipeline
`timescale 1ns/1ps

module rv_core (
  input  logic                               clk_i,
  input  logic                               reset_i,
  // Instruction strobe, accepted every cycle it is high
  input  logic                               instr_valid_i,
  input  logic [rv_core_pkg::XLEN-1:0]       instr_i,
  // Retirement strobe
  output logic                               wb_valid_o,
  output logic                               illegal_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]       wb_data_o
);

  // Pipe registers
  rv_core_pkg::id_ex_pipe_t id_ex_pipe;
  rv_core_pkg::ex_wb_pipe_t ex_wb_pipe;

  // EX result fed back for forwarding
  logic                               ex_fwd_valid;
  logic [rv_core_pkg::REG_ADDR_W-1:0] ex_fwd_rd;
  logic [rv_core_pkg::XLEN-1:0]       ex_fwd_data;

  // Register file read ports
  logic [rv_core_pkg::REG_ADDR_W-1:0] rf_raddr_a;
  logic [rv_core_pkg::REG_ADDR_W-1:0] rf_raddr_b;
  logic [rv_core_pkg::XLEN-1:0]       rf_rdata_a;
  logic [rv_core_pkg::XLEN-1:0]       rf_rdata_b;

  rv_id_stage u_id_stage (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .ex_fwd_valid_i (ex_fwd_valid),
    .ex_fwd_rd_i    (ex_fwd_rd),
    .ex_fwd_data_i  (ex_fwd_data),
    .ex_wb_pipe_i   (ex_wb_pipe),
    .rf_raddr_a_o   (rf_raddr_a),
    .rf_raddr_b_o   (rf_raddr_b),
    .rf_rdata_a_i   (rf_rdata_a),
    .rf_rdata_b_i   (rf_rdata_b),
    .id_ex_pipe_o   (id_ex_pipe)
  );

  rv_ex_stage u_ex_stage (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .id_ex_pipe_i   (id_ex_pipe),
    .ex_fwd_valid_o (ex_fwd_valid),
    .ex_fwd_rd_o    (ex_fwd_rd),
    .ex_fwd_data_o  (ex_fwd_data),
    .ex_wb_pipe_o   (ex_wb_pipe)
  );

  // Write port comes straight from the EX/WB pipe
  rv_register_file u_register_file (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .raddr_a_i    (rf_raddr_a),
    .raddr_b_i    (rf_raddr_b),
    .rdata_a_o    (rf_rdata_a),
    .rdata_b_o    (rf_rdata_b),
    .ex_wb_pipe_i (ex_wb_pipe)
  );

  // Write back view of the EX/WB pipe
  assign wb_valid_o = ex_wb_pipe.valid;
  assign illegal_o  = ex_wb_pipe.illegal;
  assign wb_rd_o    = ex_wb_pipe.rd;
  assign wb_data_o  = ex_wb_pipe.result;

endmodule

//--- tests/rv_core_tb.sv
// Testbench that replays tests/rv_core_cases.txt into rv_core and checks every retirement in order
`timescale 1ns/1ps

module rv_core_tb;

  // Expected retirement of one sent instruction
  typedef struct packed {
    logic                               illegal;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_core_pkg::XLEN-1:0]       value;
  } expect_t;

  // DUT ports
  logic                               clk_i;
  logic                               reset_i;
  logic                               instr_valid_i;
  logic [rv_core_pkg::XLEN-1:0]       instr_i;
  logic                               wb_valid_o;
  logic                               illegal_o;
  logic [rv_core_pkg::REG_ADDR_W-1:0] wb_rd_o;
  logic [rv_core_pkg::XLEN-1:0]       wb_data_o;

  // Scoreboard state
  expect_t exp_q[$];
  string   name_q[$];
  int      error_count;
  int      sent_count;
  int      retired_count;
  integer  seed;

  rv_core u_dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .illegal_o     (illegal_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Count every strobe, then pop the oldest outstanding instruction and compare
  task automatic check_retirement();
    expect_t exp;
    string   name;
    retired_count++;
    if (exp_q.size() == 0) begin
      error_count++;
      $display("A retirement appeared with no instruction outstanding");
    end else begin
      exp  = exp_q.pop_front();
      name = name_q.pop_front();
      check_value({name, " illegal"}, 32'(exp.illegal), 32'(illegal_o));
      // Rejected words carry no destination or result
      if (!exp.illegal) begin
        check_value({name, " rd"}, 32'(exp.rd), 32'(wb_rd_o));
        check_value({name, " data"}, exp.value, wb_data_o);
      end
    end
  endtask

  // Outputs sampled on the falling edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (wb_valid_o === 1'b1) begin
        check_retirement();
      end else begin
        check_value("idle strobe", 32'd0, 32'(wb_valid_o));
        check_value("idle illegal", 32'd0, 32'(illegal_o));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_idle();
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    instr_i       <= '0;
  endtask

  task automatic send_instruction(input logic [31:0] word);
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    instr_i       <= word;
  endtask

  initial begin
    int          fd;
    int          n;
    int          fields;
    int          gap;
    int          wait_cycles;
    string       line;
    string       name;
    string       kind;
    logic [31:0] word;
    logic [31:0] value;
    int          rd;
    int          b2b;
    expect_t     exp;
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    error_count   = 0;
    sent_count    = 0;
    retired_count = 0;
    seed          = 32'h1453;

    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    fd = $fopen("tests/rv_core_cases.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("Could not open tests/rv_core_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        // Skip blank and comment lines
        if (n > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%s %h %s %d %h %d", name, word, kind, rd, value, b2b);
          if (fields != 6) begin
            error_count++;
            $display("Malformed line in the cases file: %s", line);
          end else begin
            // Dependent cases go out with no gap
            if (b2b == 0) begin
              gap = $unsigned($random(seed)) % 3;
              repeat (gap) drive_idle();
            end
            exp.illegal = (kind == "I");
            exp.rd      = rd[rv_core_pkg::REG_ADDR_W-1:0];
            exp.value   = value;
            exp_q.push_back(exp);
            name_q.push_back(name);
            send_instruction(word);
            sent_count++;
          end
        end
      end
      $fclose(fd);
      drive_idle();
    end

    // Drain the pipe
    wait_cycles = 0;
    while (exp_q.size() != 0 && wait_cycles < 20) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    if (exp_q.size() != 0) begin
      error_count++;
      $display("Timed out with %0d instructions never retired", exp_q.size());
    end

    // A few quiet cycles catch stray strobes
    wait_cycles = 0;
    while (wait_cycles < 4) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    check_value("retire count", 32'(sent_count), 32'(retired_count));

    $display("Summary: %0d errors, %0d sent, %0d retired", error_count, sent_count,
             retired_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
verilog/rv_core_pkg.sv
verilog/rv_register_file.sv
verilog/rv_id_stage.sv
verilog/rv_ex_stage.sv
verilog/rv_core.sv
tests/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - verilog/rv_core_pkg.sv
      - verilog/rv_register_file.sv
      - verilog/rv_id_stage.sv
      - verilog/rv_ex_stage.sv
      - verilog/rv_core.sv
  - target: test
    files:
      - tests/rv_core_tb.sv

//--- tests/rv_core_cases.txt
# name  instr_word(hex)  kind(W=write,I=illegal)  rd(dec)  expected(hex)  back_to_back(1=no gap)
# rd and expected are ignored for kind I
addi_pos5         00500093 W 1  00000005 0
addi_neg3         ffd00113 W 2  fffffffd 0
addi_max          7ff00193 W 3  000007ff 0
addi_min          80000213 W 4  fffff800 0
add_mixed         002082b3 W 5  00000002 0
sub_pos           40208333 W 6  00000008 0
sub_neg           401103b3 W 7  fffffff8 0
sll_reg           00109433 W 8  000000a0 0
slt_neg_lt_pos    001124b3 W 9  00000001 0
sltu_big_vs_small 00113533 W 10 00000000 0
xor_reg           0020c5b3 W 11 fffffff8 0
srl_neg           00125633 W 12 07ffffc0 0
sra_neg           401256b3 W 13 ffffffc0 0
or_reg            0030e733 W 14 000007ff 0
and_reg           0021f7b3 W 15 000007fd 0
slti_neg          ffe12813 W 16 00000001 0
sltiu_all_ones    fff0b893 W 17 00000001 0
xori_invert       fff0c913 W 18 fffffffa 0
ori_imm           0f00e993 W 19 000000f5 0
andi_imm          0ff17a13 W 20 000000fd 0
slli_28           01c09a93 W 21 50000000 0
srli_4            00415b13 W 22 0fffffff 0
srai_1            40115b93 W 23 fffffffe 0
sltu_small_vs_big 0020bc33 W 24 00000001 0
slt_pos_vs_neg    0020acb3 W 25 00000000 0
fwd_seed          06400d13 W 26 00000064 0
fwd_dist1         001d0d13 W 26 00000065 1
fwd_both_ops      01ad0db3 W 27 000000ca 1
same_rd_old       00a00e13 W 28 0000000a 0
same_rd_new       01400e13 W 28 00000014 1
same_rd_young_win 01ce0eb3 W 29 00000028 1
fwd_src_a         00300f13 W 30 00000003 0
fwd_src_b         00900f93 W 31 00000009 1
fwd_ex_and_wb     41ef82b3 W 5  00000006 1
fwd_wb_and_rf     01ff0333 W 6  0000000c 1
x0_write          04d08013 W 0  00000052 0
x0_read_ex        001003b3 W 7  00000005 1
x0_read_wb        00006433 W 8  00000000 1
illegal_load      0000a483 I 0  00000000 0
illegal_funct7    021084b3 I 0  00000000 1
after_illegal     00148533 W 10 00000006 1
x9_kept           00048593 W 11 00000001 0
illegal_srai      42125613 I 0  00000000 0
x12_kept          00060693 W 13 07ffffc0 1
